//--- list.f
+incdir+hdl
hdl/mem_wh_pkg.sv
hdl/mem_cmd_encode.sv
hdl/wh_packet_to_flits.sv
hdl/wh_flits_to_packet.sv
hdl/mem_link_master.sv
hdl/mem_link_endpoint.sv
hdl/mem_link_top.sv
sim/mem_link_tb.sv

//--- Makefile
TOP := mem_link_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

//--- sim/mem_link_tb.sv
// ==================================================
// Memory link testbench
// Directed tests checked against a word model
// ==================================================
`timescale 1ns/1ns
`include "mem_wh_settings.svh"

module mem_link_tb
   import mem_wh_pkg::*;
();

   localparam int timeout_lp = 200;  // Cycles per wait

   logic                      clk_i;
   logic                      arst_n_i;
   mem_msg_s                  mem_cmd_i;
   logic                      mem_cmd_v_i;
   logic                      mem_cmd_ready_o;
   mem_msg_s                  mem_resp_o;
   logic                      mem_resp_v_o;
   logic                      mem_resp_yumi_i;
   logic [`MEM_WH_CORD_W-1:0] my_cord_i;
   logic [`MEM_WH_CORD_W-1:0] dst_cord_i;
   logic [`MEM_WH_CORD_W-1:0] endpoint_cord_i;

   logic [`MEM_WH_DATA_W-1:0] model [`MEM_WH_MEM_DEPTH];
   mem_msg_s                  exp_q [$];  // Responses still owed in command order
   logic [31:0]               rng_state;
   int                        mismatch_cnt;
   int                        other_cnt;

   mem_link_top mem_link_top_inst (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .mem_cmd_i      (mem_cmd_i),
      .mem_cmd_v_i    (mem_cmd_v_i),
      .mem_cmd_ready_o(mem_cmd_ready_o),
      .mem_resp_o     (mem_resp_o),
      .mem_resp_v_o   (mem_resp_v_o),
      .mem_resp_yumi_i(mem_resp_yumi_i),
      .my_cord_i      (my_cord_i),
      .dst_cord_i     (dst_cord_i),
      .endpoint_cord_i(endpoint_cord_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Applies a command to the model and returns the response it owes
   function automatic mem_msg_s model_access(input mem_opcode_e op,
                                             input logic [`MEM_WH_ADDR_W-1:0] addr,
                                             input logic [`MEM_WH_DATA_W-1:0] data);
      int       idx;
      mem_msg_s resp;
      idx             = int'(addr) % `MEM_WH_MEM_DEPTH;
      resp.hdr.opcode = op;
      resp.hdr.addr   = addr;
      if (op == e_mem_write) begin
         model[idx] = data;
         resp.data  = '0;  // Write responses carry no data
      end else begin
         resp.data = model[idx];
      end
      return resp;
   endfunction

   // ==================================================
   // Port tasks entered and left 1 ns after a rising edge
   // ==================================================
   task automatic send_cmd(input mem_opcode_e op, input logic [`MEM_WH_ADDR_W-1:0] addr,
                           input logic [`MEM_WH_DATA_W-1:0] data, input bit expect_resp);
      int cnt;
      bit accepted;
      cnt                  = 0;
      mem_cmd_i.data       = data;
      mem_cmd_i.hdr.opcode = op;
      mem_cmd_i.hdr.addr   = addr;
      mem_cmd_v_i          = 1'b1;
      while (!mem_cmd_ready_o && cnt < timeout_lp) begin
         @(posedge clk_i);
         #1;
         cnt++;
      end
      accepted = mem_cmd_ready_o;
      assert (accepted) else begin
         $display("Timeout at %0t: command port never became ready", $time);
         other_cnt++;
      end
      @(posedge clk_i);
      #1;
      mem_cmd_v_i = 1'b0;
      if (accepted && expect_resp) begin
         exp_q.push_back(model_access(op, addr, data));
      end
   endtask

   task automatic get_resp();
      int       cnt;
      mem_msg_s exp;
      cnt = 0;
      while (!mem_resp_v_o && cnt < timeout_lp) begin
         @(posedge clk_i);
         #1;
         cnt++;
      end
      assert (mem_resp_v_o) else begin
         $display("Timeout at %0t: no response arrived", $time);
         other_cnt++;
      end
      if (mem_resp_v_o) begin
         assert (exp_q.size() != 0) else begin
            $display("Error at %0t: a response arrived that no command asked for", $time);
            other_cnt++;
         end
         if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            assert (mem_resp_o == exp) else begin
               $display("MISMATCH at %0t: op %0d addr %h data %h, expected %0d %h %h",
                        $time, mem_resp_o.hdr.opcode, mem_resp_o.hdr.addr, mem_resp_o.data,
                        exp.hdr.opcode, exp.hdr.addr, exp.data);
               mismatch_cnt++;
            end
         end
         mem_resp_yumi_i = 1'b1;
         @(posedge clk_i);
         #1;
         mem_resp_yumi_i = 1'b0;
      end
   endtask

   task automatic check_no_resp();
      int cnt;
      cnt = 0;
      while (!mem_resp_v_o && cnt < timeout_lp) begin
         @(posedge clk_i);
         #1;
         cnt++;
      end
      assert (!mem_resp_v_o) else begin
         $display("Error at %0t: a dropped packet produced a response", $time);
         other_cnt++;
         get_resp();  // Drain it so later tests stay aligned
      end
   endtask

   // ==================================================
   // Directed tests
   // ==================================================
   task automatic reset_state_and_reads();
      assert (!mem_resp_v_o && mem_cmd_ready_o) else begin
         $display("MISMATCH at %0t: after reset resp_v %b cmd_ready %b, expected 0 and 1",
                  $time, mem_resp_v_o, mem_cmd_ready_o);
         mismatch_cnt++;
      end
      send_cmd(e_mem_read, 8'h00, '0, 1'b1);
      get_resp();
      send_cmd(e_mem_read, 8'h0b, '0, 1'b1);
      get_resp();
      send_cmd(e_mem_read, 8'h9e, '0, 1'b1);
      get_resp();
   endtask

   task automatic write_then_read();
      send_cmd(e_mem_write, 8'h07, 32'hcafe_f00d, 1'b1);
      get_resp();
      send_cmd(e_mem_read, 8'h07, '0, 1'b1);
      get_resp();
      send_cmd(e_mem_write, 8'h23, 32'h1357_9bdf, 1'b1);  // Aliases word 3
      get_resp();
      send_cmd(e_mem_read, 8'h03, '0, 1'b1);
      get_resp();
   endtask

   task automatic random_traffic();
      logic [31:0] r;
      logic [31:0] d;
      repeat (40) begin
         r = next_rand();
         d = next_rand();
         send_cmd(r[0] ? e_mem_write : e_mem_read, r[15:8], d, 1'b1);
         get_resp();
      end
   endtask

   task automatic held_responses_stall();
      int cnt;
      cnt = 0;
      send_cmd(e_mem_write, 8'h09, next_rand(), 1'b1);
      send_cmd(e_mem_read, 8'h09, '0, 1'b1);
      send_cmd(e_mem_write, 8'h0a, next_rand(), 1'b1);
      send_cmd(e_mem_read, 8'h0a, '0, 1'b1);
      // Every stage full once the first response waits at the port
      while ((mem_cmd_ready_o || !mem_resp_v_o) && cnt < timeout_lp) begin
         @(posedge clk_i);
         #1;
         cnt++;
      end
      assert (!mem_cmd_ready_o && mem_resp_v_o) else begin
         $display("Timeout at %0t: command port did not stall under back-pressure", $time);
         other_cnt++;
      end
      repeat (10) begin
         @(posedge clk_i);
         #1;
         assert (!mem_cmd_ready_o) else begin
            $display("MISMATCH at %0t: cmd_ready rose while responses were held", $time);
            mismatch_cnt++;
         end
      end
      repeat (4) get_resp();
   endtask

   task automatic misrouted_write_dropped();
      dst_cord_i = 4'h7;
      send_cmd(e_mem_write, 8'h07, 32'hbad0_bad0, 1'b0);
      dst_cord_i = 4'h3;
      check_no_resp();
      send_cmd(e_mem_read, 8'h07, '0, 1'b1);  // Old value expected
      get_resp();
   endtask

   // ==================================================
   // Main sequence
   // ==================================================
   initial begin
      rng_state       = 32'h2eea_0575;
      mismatch_cnt    = 0;
      other_cnt       = 0;
      arst_n_i        = 1'b0;
      mem_cmd_i       = '0;
      mem_cmd_v_i     = 1'b0;
      mem_resp_yumi_i = 1'b0;
      my_cord_i       = 4'h1;
      dst_cord_i      = 4'h3;
      endpoint_cord_i = 4'h3;
      foreach (model[i]) model[i] = '0;
      repeat (3) @(posedge clk_i);
      #1;
      arst_n_i = 1'b1;

      reset_state_and_reads();
      write_then_read();
      random_traffic();
      held_responses_stall();
      misrouted_write_dropped();

      $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
      if (mismatch_cnt + other_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- hdl/mem_link_top.sv
// ==================================================
// Memory link top with master and endpoint on two links
// ==================================================
`timescale 1ns/1ns
`include "mem_wh_settings.svh"

module mem_link_top
   import mem_wh_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      arst_n_i,

   input  mem_msg_s                  mem_cmd_i,
   input  logic                      mem_cmd_v_i,
   output logic                      mem_cmd_ready_o,
   output mem_msg_s                  mem_resp_o,
   output logic                      mem_resp_v_o,
   input  logic                      mem_resp_yumi_i,

   input  logic [`MEM_WH_CORD_W-1:0] my_cord_i,
   input  logic [`MEM_WH_CORD_W-1:0] dst_cord_i,
   input  logic [`MEM_WH_CORD_W-1:0] endpoint_cord_i
);

   wh_link_s cmd_link;
   logic     cmd_link_ready;
   wh_link_s resp_link;
   logic     resp_link_ready;

   mem_link_master mem_link_master_inst (
      .clk_i            (clk_i),
      .arst_n_i         (arst_n_i),
      .mem_cmd_i        (mem_cmd_i),
      .mem_cmd_v_i      (mem_cmd_v_i),
      .mem_cmd_ready_o  (mem_cmd_ready_o),
      .mem_resp_o       (mem_resp_o),
      .mem_resp_v_o     (mem_resp_v_o),
      .mem_resp_yumi_i  (mem_resp_yumi_i),
      .my_cord_i        (my_cord_i),
      .dst_cord_i       (dst_cord_i),
      .cmd_link_o       (cmd_link),
      .cmd_link_ready_i (cmd_link_ready),
      .resp_link_i      (resp_link),
      .resp_link_ready_o(resp_link_ready)
   );

   mem_link_endpoint mem_link_endpoint_inst (
      .clk_i            (clk_i),
      .arst_n_i         (arst_n_i),
      .endpoint_cord_i  (endpoint_cord_i),
      .cmd_link_i       (cmd_link),
      .cmd_link_ready_o (cmd_link_ready),
      .resp_link_o      (resp_link),
      .resp_link_ready_i(resp_link_ready)
   );

endmodule

//--- hdl/mem_link_endpoint.sv
// ==================================================
// Remote memory endpoint
// Filters by coordinate, executes, sends response
// ==================================================
`timescale 1ns/1ns
`include "mem_wh_settings.svh"

module mem_link_endpoint
   import mem_wh_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  logic [`MEM_WH_CORD_W-1:0] endpoint_cord_i,

   input  wh_link_s                  cmd_link_i,
   output logic                      cmd_link_ready_o,
   output wh_link_s                  resp_link_o,
   input  logic                      resp_link_ready_i
);

   localparam int idx_w_lp = $clog2(`MEM_WH_MEM_DEPTH);

   wh_packet_s                cmd_pkt;
   logic                      cmd_v;
   logic                      cmd_yumi;
   logic                      hit;
   logic                      is_write;
   logic                      resp_ready;
   logic                      exec;
   logic [idx_w_lp-1:0]       idx;
   logic [`MEM_WH_DATA_W-1:0] rd_data;
   wh_header_s                resp_hdr;
   wh_packet_s                resp_pkt;
   logic [`MEM_WH_DATA_W-1:0] mem_r [`MEM_WH_MEM_DEPTH];

   wh_flits_to_packet cmd_rx_inst (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .link_i      (cmd_link_i),
      .link_ready_o(cmd_link_ready_o),
      .packet_o    (cmd_pkt),
      .v_o         (cmd_v),
      .yumi_i      (cmd_yumi)
   );

   assign hit      = (cmd_pkt.header.dst_cord == endpoint_cord_i);
   assign is_write = (cmd_pkt.header.msg_hdr.opcode == e_mem_write);
   assign idx      = cmd_pkt.header.msg_hdr.addr[idx_w_lp-1:0];  // Wraps at depth
   assign exec     = cmd_v & hit & resp_ready;
   assign cmd_yumi = exec | (cmd_v & ~hit);  // Misrouted packets just drain

   // ==================================================
   // Register memory
   // ==================================================
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         mem_r <= '{default: '0};
      end else if (exec && is_write) begin
         mem_r[idx] <= cmd_pkt.data;
      end
   end

   assign rd_data = is_write ? '0 : mem_r[idx];

   // Response goes back to the sender
   mem_cmd_encode #(.response_p(1'b1)) resp_encode_inst (
      .msg_hdr_i  (cmd_pkt.header.msg_hdr),
      .src_cord_i (endpoint_cord_i),
      .dst_cord_i (cmd_pkt.header.src_cord),
      .wh_header_o(resp_hdr)
   );

   assign resp_pkt = '{data: rd_data, header: resp_hdr};

   wh_packet_to_flits resp_tx_inst (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .packet_i    (resp_pkt),
      .v_i         (cmd_v & hit),
      .ready_o     (resp_ready),
      .link_o      (resp_link_o),
      .link_ready_i(resp_link_ready_i)
   );

endmodule

//--- hdl/mem_link_master.sv
// ==================================================
// Memory to wormhole link master
// Sends commands as packets, rebuilds responses
// ==================================================
`timescale 1ns/1ns
`include "mem_wh_settings.svh"

module mem_link_master
   import mem_wh_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      arst_n_i,

   // Memory side
   input  mem_msg_s                  mem_cmd_i,
   input  logic                      mem_cmd_v_i,
   output logic                      mem_cmd_ready_o,

   output mem_msg_s                  mem_resp_o,
   output logic                      mem_resp_v_o,
   input  logic                      mem_resp_yumi_i,

   // Routing
   input  logic [`MEM_WH_CORD_W-1:0] my_cord_i,
   input  logic [`MEM_WH_CORD_W-1:0] dst_cord_i,

   // Links
   output wh_link_s                  cmd_link_o,
   input  logic                      cmd_link_ready_i,
   input  wh_link_s                  resp_link_i,
   output logic                      resp_link_ready_o
);

   wh_header_s cmd_header;
   wh_packet_s cmd_packet;
   wh_packet_s resp_packet;

   mem_cmd_encode #(.response_p(1'b0)) cmd_encode_inst (
      .msg_hdr_i  (mem_cmd_i.hdr),
      .src_cord_i (my_cord_i),
      .dst_cord_i (dst_cord_i),
      .wh_header_o(cmd_header)
   );

   assign cmd_packet = '{data: mem_cmd_i.data, header: cmd_header};

   wh_packet_to_flits cmd_tx_inst (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .packet_i    (cmd_packet),
      .v_i         (mem_cmd_v_i),
      .ready_o     (mem_cmd_ready_o),
      .link_o      (cmd_link_o),
      .link_ready_i(cmd_link_ready_i)
   );

   wh_flits_to_packet resp_rx_inst (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .link_i      (resp_link_i),
      .link_ready_o(resp_link_ready_o),
      .packet_o    (resp_packet),
      .v_o         (mem_resp_v_o),
      .yumi_i      (mem_resp_yumi_i)
   );

   // Routing fields are dropped here
   assign mem_resp_o = '{data: resp_packet.data, hdr: resp_packet.header.msg_hdr};

endmodule

//--- hdl/wh_flits_to_packet.sv
// ==================================================
// Wormhole deserializer
// Collects link flits into one packet held until yumi
// ==================================================
`timescale 1ns/1ns
`include "mem_wh_settings.svh"

module wh_flits_to_packet
   import mem_wh_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_n_i,

   input  wh_link_s   link_i,
   output logic       link_ready_o,

   output wh_packet_s packet_o,
   output logic       v_o,
   input  logic       yumi_i
);

   localparam int pkt_flits_lp =
      ($bits(wh_packet_s) + `MEM_WH_FLIT_W - 1) / `MEM_WH_FLIT_W;
   localparam int flits_w_lp = pkt_flits_lp * `MEM_WH_FLIT_W;
   localparam int slot_w_lp  = $clog2(pkt_flits_lp);

   logic [flits_w_lp-1:0]    pkt_r;
   logic [`MEM_WH_LEN_W-1:0] cnt_r;
   logic [slot_w_lp-1:0]     slot_r;
   logic                     active_r;  // Mid-packet
   logic                     full_r;
   logic                     flit_acc;
   logic [`MEM_WH_LEN_W-1:0] first_len;

   assign link_ready_o = ~full_r;
   assign flit_acc     = link_i.v & ~full_r;
   assign first_len    = link_i.data[`MEM_WH_CORD_W +: `MEM_WH_LEN_W];

   assign packet_o = pkt_r[$bits(wh_packet_s)-1:0];
   assign v_o      = full_r;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         active_r <= 1'b0;
         full_r   <= 1'b0;
         cnt_r    <= '0;
         slot_r   <= '0;
      end else begin
         if (yumi_i) begin
            full_r <= 1'b0;
         end
         if (flit_acc && !active_r) begin
            cnt_r    <= first_len;
            slot_r   <= slot_w_lp'(1);
            active_r <= (first_len != '0);
            full_r   <= (first_len == '0);
         end else if (flit_acc) begin
            cnt_r  <= cnt_r - 1'b1;
            slot_r <= slot_r + 1'b1;
            if (cnt_r == `MEM_WH_LEN_W'(1)) begin
               active_r <= 1'b0;
               full_r   <= 1'b1;
            end
         end
      end
   end

   // First flit clears the slots, so unsent data reads as zero
   always_ff @(posedge clk_i) begin
      if (flit_acc && !active_r) begin
         pkt_r <= flits_w_lp'(link_i.data);
      end else if (flit_acc) begin
         pkt_r[slot_r*`MEM_WH_FLIT_W +: `MEM_WH_FLIT_W] <= link_i.data;
      end
   end

endmodule

//--- hdl/wh_packet_to_flits.sv
// ==================================================
// Wormhole serializer
// Sends one packet as len+1 flits on a link
// ==================================================
`timescale 1ns/1ns
`include "mem_wh_settings.svh"

module wh_packet_to_flits
   import mem_wh_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_n_i,

   input  wh_packet_s packet_i,
   input  logic       v_i,
   output logic       ready_o,

   output wh_link_s   link_o,
   input  logic       link_ready_i
);

   localparam int pkt_flits_lp =
      ($bits(wh_packet_s) + `MEM_WH_FLIT_W - 1) / `MEM_WH_FLIT_W;
   localparam int flits_w_lp = pkt_flits_lp * `MEM_WH_FLIT_W;

   logic                     busy_r;
   logic [`MEM_WH_LEN_W-1:0] cnt_r;   // Flits left after the current one
   logic [flits_w_lp-1:0]    sreg_r;
   logic                     load;
   logic                     flit_sent;

   assign ready_o   = ~busy_r;
   assign load      = v_i & ~busy_r;
   assign flit_sent = busy_r & link_ready_i;

   assign link_o.v    = busy_r;
   assign link_o.data = sreg_r[`MEM_WH_FLIT_W-1:0];

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_r <= 1'b0;
         cnt_r  <= '0;
      end else if (load) begin
         busy_r <= 1'b1;
         cnt_r  <= packet_i.header.len;
      end else if (flit_sent) begin
         if (cnt_r == '0) begin
            busy_r <= 1'b0;  // Last flit gone
         end else begin
            cnt_r <= cnt_r - 1'b1;
         end
      end
   end

   // Packet is padded with zeros up to whole flits
   always_ff @(posedge clk_i) begin
      if (load) begin
         sreg_r <= flits_w_lp'(packet_i);
      end else if (flit_sent) begin
         sreg_r <= sreg_r >> `MEM_WH_FLIT_W;
      end
   end

endmodule

//--- hdl/mem_cmd_encode.sv
// ==================================================
// Wormhole header encoder
// Fills routing fields and picks len from the opcode
// ==================================================
`timescale 1ns/1ns
`include "mem_wh_settings.svh"

module mem_cmd_encode
   import mem_wh_pkg::*;
#(
   parameter bit response_p = 1'b0  // Response encoding flips the length choice
) (
   input  mem_msg_hdr_s              msg_hdr_i,
   input  logic [`MEM_WH_CORD_W-1:0] src_cord_i,
   input  logic [`MEM_WH_CORD_W-1:0] dst_cord_i,
   output wh_header_s                wh_header_o
);

   localparam logic [`MEM_WH_LEN_W-1:0] len_short_lp = 1;  // Header only in 2 flits
   localparam logic [`MEM_WH_LEN_W-1:0] len_long_lp  = 3;  // Header and data in 4 flits

   logic carries_data;

   // Commands carry data on writes, responses carry it on reads
   assign carries_data = (msg_hdr_i.opcode == e_mem_write) ^ response_p;

   assign wh_header_o.msg_hdr  = msg_hdr_i;
   assign wh_header_o.src_cord = src_cord_i;
   assign wh_header_o.dst_cord = dst_cord_i;
   assign wh_header_o.len      = carries_data ? len_long_lp : len_short_lp;

endmodule

//--- hdl/mem_wh_pkg.sv
// ==================================================
// Memory wormhole types
// Message, header, packet and link structs
// ==================================================
`include "mem_wh_settings.svh"

package mem_wh_pkg;

   typedef enum logic [1:0] {
      e_mem_read  = 2'b00,
      e_mem_write = 2'b01
   } mem_opcode_e;

   // ==================================================
   // Memory side
   // ==================================================
   typedef struct packed {
      mem_opcode_e                opcode;
      logic [`MEM_WH_ADDR_W-1:0] addr;
   } mem_msg_hdr_s;

   typedef struct packed {
      logic [`MEM_WH_DATA_W-1:0] data;
      mem_msg_hdr_s              hdr;
   } mem_msg_s;

   // ==================================================
   // Wormhole side
   // ==================================================
   // dst_cord and len land in the first flit
   typedef struct packed {
      mem_msg_hdr_s              msg_hdr;
      logic [`MEM_WH_CORD_W-1:0] src_cord;
      logic [`MEM_WH_LEN_W-1:0]  len;
      logic [`MEM_WH_CORD_W-1:0] dst_cord;
   } wh_header_s;

   typedef struct packed {
      logic [`MEM_WH_DATA_W-1:0] data;
      wh_header_s                header;
   } wh_packet_s;

   typedef struct packed {
      logic                      v;
      logic [`MEM_WH_FLIT_W-1:0] data;
   } wh_link_s;

endpackage

//--- hdl/mem_wh_settings.svh
// ==================================================
// Memory wormhole link settings
// Field widths and endpoint memory depth
// ==================================================
`ifndef MEM_WH_SETTINGS_SVH
`define MEM_WH_SETTINGS_SVH

// Link and message widths
`define MEM_WH_FLIT_W    16
`define MEM_WH_DATA_W    32
`define MEM_WH_ADDR_W    8

// Routing fields
`define MEM_WH_CORD_W    4
`define MEM_WH_LEN_W     4  // Counts flits after the first

// Addresses wrap at the endpoint memory depth
`define MEM_WH_MEM_DEPTH 16

`endif
